//--- common/sprite_pkg.sv
// sizes, object descriptor, span record, AXI4-Lite channel structs and scanner states
package sprite_pkg;

    // ========================================================================
    // sizes and addresses
    // ========================================================================
    localparam int obj_count     = 128;
    localparam int staging_words = 256;
    // x positions wrap modulo the line RAM depth
    localparam int line_len      = 512;
    localparam int visible_px    = 320;
    localparam logic [31:0] rom_base  = 32'h0010_0000;
    localparam logic [1:0]  resp_okay = 2'b00;

    // one object table entry, staging word 2k is the low half of object k
    typedef struct packed {
        logic [5:0]  rsv_hi;
        logic [9:0]  x;
        logic [1:0]  width;
        logic [1:0]  height;
        logic        flip_x;
        logic        flip_y;
        logic [5:0]  rsv_mid;
        logic [3:0]  color;
        logic [15:0] code;
        logic [6:0]  rsv_lo;
        logic [8:0]  y;
    } obj_desc_t;

    // sixteen pixels as four 16-bit bitplanes, leftmost pixel in bit 15
    typedef struct packed {
        logic [63:0] data;
        logic [3:0]  color;
        logic [9:0]  x_start;
    } span_t;

    // ========================================================================
    // AXI4-Lite channels
    // ========================================================================
    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
    } axil_wr_rsp_t;

    typedef struct packed {
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_rd_req_t;

    // ROM reads use all 64 data bits, CPU reads return data in the low 32
    typedef struct packed {
        logic        arready;
        logic [63:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rd_rsp_t;

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_size,
        st_code,
        st_fetch,
        st_wait_rom,
        st_hand,
        st_next
    } scan_state_e;

endpackage

//--- files.f
+incdir+verification
common/sprite_pkg.sv
source/obj_ram_port.sv
source/obj_dma.sv
sprite/sprite_scanner.sv
sprite/sprite_line_buffer.sv
source/sprite_top.sv
verification/sprite_tb.sv

//--- source/obj_dma.sv
// staging RAM to object table copy engine and the object table read port
`timescale 1ns/1ps

module obj_dma import sprite_pkg::*; (
    input  logic        CLK_32M,
    input  logic        rst,
    input  logic        dma_start,
    output logic        dma_busy,
    output logic [7:0]  dma_addr,
    input  logic [31:0] dma_data,
    input  logic [6:0]  obj_index,
    output obj_desc_t   obj_entry
);

    obj_desc_t   obj_table [obj_count];

    logic [8:0]  copy_cnt;
    logic [8:0]  word_idx;
    logic        word_vld;
    logic [31:0] lo_word;

    assign dma_addr = copy_cnt[7:0];

    // the staging RAM answers one cycle late, so the word arriving now
    // belongs to the previous count
    assign word_idx = copy_cnt - 9'd1;
    assign word_vld = dma_busy && (copy_cnt != 9'd0);

    // ========================================================================
    // copy sequencing, 256 reads plus one cycle of RAM latency
    // ========================================================================
    always_ff @(posedge CLK_32M) begin
        if (rst) begin
            dma_busy <= 1'b0;
            copy_cnt <= 9'd0;
        end else if (!dma_busy) begin
            if (dma_start) begin
                dma_busy <= 1'b1;
                copy_cnt <= 9'd0;
            end
        end else begin
            copy_cnt <= copy_cnt + 9'd1;
            if (copy_cnt == 9'(staging_words)) begin
                dma_busy <= 1'b0;
            end
        end
    end

    // an entry is written when its high word comes in
    always_ff @(posedge CLK_32M) begin
        if (word_vld) begin
            if (!word_idx[0]) begin
                lo_word <= dma_data;
            end else begin
                obj_table[word_idx[7:1]] <= obj_desc_t'({dma_data, lo_word});
            end
        end
        obj_entry <= obj_table[obj_index];
    end

endmodule

//--- source/obj_ram_port.sv
// AXI4-Lite slave for CPU access to the byte-strobed staging RAM, with a DMA read port
`timescale 1ns/1ps

module obj_ram_port import sprite_pkg::*; (
    input  logic         CLK_32M,
    input  logic         rst,
    input  axil_wr_req_t wr_req,
    output axil_wr_rsp_t wr_rsp,
    input  axil_rd_req_t rd_req,
    output axil_rd_rsp_t rd_rsp,
    input  logic [7:0]   dma_addr,
    output logic [31:0]  dma_data
);

    logic [31:0] stage_ram [staging_words];

    logic        port_live;
    logic        aw_got;
    logic        w_got;
    logic        bvalid;
    logic        wr_fire;
    logic [7:0]  aw_addr_q;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;
    logic        ar_pend;
    logic        rvalid;
    logic [7:0]  ar_addr_q;
    logic [31:0] rd_data_q;

    // the write happens once both address and data have been taken
    assign wr_fire = aw_got && w_got;

    // all readies stay low in the first cycle after reset
    assign wr_rsp.awready = port_live && !aw_got && !bvalid;
    assign wr_rsp.wready  = port_live && !w_got && !bvalid;
    assign wr_rsp.bresp   = resp_okay;
    assign wr_rsp.bvalid  = bvalid;
    assign rd_rsp.arready = port_live && !ar_pend && !rvalid;
    assign rd_rsp.rdata   = {32'd0, rd_data_q};
    assign rd_rsp.rresp   = resp_okay;
    assign rd_rsp.rvalid  = rvalid;

    always_ff @(posedge CLK_32M) begin
        if (rst) begin
            port_live <= 1'b0;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            bvalid    <= 1'b0;
            ar_pend   <= 1'b0;
            rvalid    <= 1'b0;
        end else begin
            port_live <= 1'b1;
            if (wr_rsp.awready && wr_req.awvalid) begin
                aw_got    <= 1'b1;
                aw_addr_q <= wr_req.awaddr[7:0];
            end
            if (wr_rsp.wready && wr_req.wvalid) begin
                w_got    <= 1'b1;
                w_data_q <= wr_req.wdata;
                w_strb_q <= wr_req.wstrb;
            end
            if (wr_fire) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
            end else if (bvalid && wr_req.bready) begin
                bvalid <= 1'b0;
            end

            // read data is registered out of the RAM one cycle after the address
            if (rd_rsp.arready && rd_req.arvalid) begin
                ar_pend   <= 1'b1;
                ar_addr_q <= rd_req.araddr[7:0];
            end
            if (ar_pend) begin
                ar_pend <= 1'b0;
                rvalid  <= 1'b1;
            end else if (rvalid && rd_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK_32M) begin
        if (wr_fire) begin
            for (int b = 0; b < 4; b++) begin
                if (w_strb_q[b]) begin
                    stage_ram[aw_addr_q][b*8 +: 8] <= w_data_q[b*8 +: 8];
                end
            end
        end
        if (ar_pend) begin
            rd_data_q <= stage_ram[ar_addr_q];
        end
        dma_data <= stage_ram[dma_addr];
    end

endmodule

//--- source/sprite_top.sv
// sprite engine top level with CPU port, DMA, scanner and line buffer
`timescale 1ns/1ps

module sprite_top import sprite_pkg::*; (
    input  logic         CLK_32M,
    input  logic         rst,
    input  axil_wr_req_t cpu_wr_req,
    output axil_wr_rsp_t cpu_wr_rsp,
    input  axil_rd_req_t cpu_rd_req,
    output axil_rd_rsp_t cpu_rd_rsp,
    input  logic         dma_start,
    output logic         dma_busy,
    output axil_rd_req_t rom_req,
    input  axil_rd_rsp_t rom_rsp,
    input  logic         line_start,
    input  logic [8:0]   vpos,
    input  logic         ce_pix,
    output logic [7:0]   pix,
    output logic         pix_valid
);

    logic [7:0]  dma_addr;
    logic [31:0] dma_data;
    logic [6:0]  obj_index;
    obj_desc_t   obj_entry;
    span_t       span;
    logic        span_req;
    logic        span_ack;

    obj_ram_port obj_ram_port_i (
        .CLK_32M  (CLK_32M),
        .rst      (rst),
        .wr_req   (cpu_wr_req),
        .wr_rsp   (cpu_wr_rsp),
        .rd_req   (cpu_rd_req),
        .rd_rsp   (cpu_rd_rsp),
        .dma_addr (dma_addr),
        .dma_data (dma_data)
    );

    obj_dma obj_dma_i (
        .CLK_32M   (CLK_32M),
        .rst       (rst),
        .dma_start (dma_start),
        .dma_busy  (dma_busy),
        .dma_addr  (dma_addr),
        .dma_data  (dma_data),
        .obj_index (obj_index),
        .obj_entry (obj_entry)
    );

    sprite_scanner sprite_scanner_i (
        .CLK_32M    (CLK_32M),
        .rst        (rst),
        .line_start (line_start),
        .vpos       (vpos),
        .dma_busy   (dma_busy),
        .obj_index  (obj_index),
        .obj_entry  (obj_entry),
        .rom_req    (rom_req),
        .rom_rsp    (rom_rsp),
        .span       (span),
        .span_req   (span_req),
        .span_ack   (span_ack)
    );

    sprite_line_buffer sprite_line_buffer_i (
        .CLK_32M    (CLK_32M),
        .rst        (rst),
        .line_start (line_start),
        .ce_pix     (ce_pix),
        .span       (span),
        .span_req   (span_req),
        .span_ack   (span_ack),
        .pix        (pix),
        .pix_valid  (pix_valid)
    );

endmodule

//--- sprite/sprite_line_buffer.sv
// double-buffered line RAMs, 16-cycle span plotter and pixel scan-out with clear-behind
`timescale 1ns/1ps

module sprite_line_buffer import sprite_pkg::*; (
    input  logic       CLK_32M,
    input  logic       rst,
    input  logic       line_start,
    input  logic       ce_pix,
    input  span_t      span,
    input  logic       span_req,
    output logic       span_ack,
    output logic [7:0] pix,
    output logic       pix_valid
);

    logic [7:0]  line_ram [2][line_len];
    // bank being displayed, the other one is plotted
    logic        front_sel;

    logic [4:0]  plot_cnt;
    logic [63:0] plot_data;
    logic [3:0]  plot_color;
    logic [8:0]  plot_pos;
    logic [3:0]  plot_bits;
    logic        plot_we;

    logic [8:0]  scan_pos;
    logic        scan_rd;
    logic [7:0]  scan_q;

    logic        bank_we   [2];
    logic [8:0]  bank_addr [2];
    logic [7:0]  bank_wd   [2];

    // plane 3 supplies the top bit of the pixel
    assign plot_bits = {plot_data[63], plot_data[47], plot_data[31], plot_data[15]};
    assign plot_we   = (plot_cnt != 5'd0) && (plot_bits != 4'd0);
    assign scan_rd   = ce_pix && !line_start && (scan_pos < 9'(visible_px));
    assign pix       = scan_q;

    // the front bank takes the clear-behind, the back bank takes the plotter
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            if (front_sel == 1'(b)) begin
                bank_we[b]   = scan_rd;
                bank_addr[b] = scan_pos;
                bank_wd[b]   = 8'd0;
            end else begin
                bank_we[b]   = plot_we;
                bank_addr[b] = plot_pos;
                bank_wd[b]   = {plot_color, plot_bits};
            end
        end
    end

    always_ff @(posedge CLK_32M) begin
        for (int b = 0; b < 2; b++) begin
            if (bank_we[b]) begin
                line_ram[b][bank_addr[b]] <= bank_wd[b];
            end
        end
        scan_q <= line_ram[front_sel][scan_pos];
    end

    // ========================================================================
    // span plotter
    // ========================================================================
    always_ff @(posedge CLK_32M) begin
        if (rst) begin
            plot_cnt <= 5'd0;
            span_ack <= 1'b0;
        end else if (plot_cnt != 5'd0) begin
            plot_cnt  <= plot_cnt - 5'd1;
            plot_pos  <= plot_pos + 9'd1;
            plot_data <= {plot_data[62:0], 1'b0};
        end else if (span_req != span_ack) begin
            plot_cnt   <= 5'd16;
            plot_data  <= span.data;
            plot_color <= span.color;
            plot_pos   <= span.x_start[8:0];
            span_ack   <= span_req;
        end
    end

    // ========================================================================
    // scan-out
    // ========================================================================
    always_ff @(posedge CLK_32M) begin
        if (rst) begin
            front_sel <= 1'b0;
            // no output until the first line starts
            scan_pos  <= 9'(visible_px);
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= scan_rd;
            if (line_start) begin
                front_sel <= ~front_sel;
                scan_pos  <= 9'd0;
            end else if (scan_rd) begin
                scan_pos <= scan_pos + 9'd1;
            end
        end
    end

endmodule

//--- sprite/sprite_scanner.sv
// per-line object selection, graphics ROM read master, de-swizzle and span hand-off
`timescale 1ns/1ps

module sprite_scanner import sprite_pkg::*; (
    input  logic         CLK_32M,
    input  logic         rst,
    input  logic         line_start,
    input  logic [8:0]   vpos,
    input  logic         dma_busy,
    output logic [6:0]   obj_index,
    input  obj_desc_t    obj_entry,
    output axil_rd_req_t rom_req,
    input  axil_rd_rsp_t rom_rsp,
    output span_t        span,
    output logic         span_req,
    input  logic         span_ack
);

    scan_state_e state;
    obj_desc_t   cur;
    logic [7:0]  obj_ptr;
    logic [8:0]  scan_line;
    logic [8:0]  rel_y;
    logic [8:0]  height_px;
    logic [3:0]  width_cnt;
    logic [2:0]  span_col;
    logic [15:0] code_idx;
    logic [63:0] span_data;
    logic        ar_valid;
    logic [31:0] ar_addr;
    logic        r_wait;

    logic [8:0]  row_y;
    logic [2:0]  col_eff;
    logic        covers;

    assign covers  = rel_y < height_px;
    assign row_y   = cur.flip_y ? (height_px - rel_y - 9'd1) : rel_y;
    // wraps modulo 8, which also holds for the eight-span width
    assign col_eff = cur.flip_x ? (width_cnt[2:0] - span_col - 3'd1) : span_col;

    assign obj_index       = obj_ptr[6:0];
    assign rom_req.araddr  = ar_addr;
    assign rom_req.arvalid = ar_valid;
    assign rom_req.rready  = r_wait;

    // the ROM word holds two groups of four 8-bit planes, each 16-bit output
    // plane joins one byte from each group
    function automatic logic [63:0] deswizzle(input logic [63:0] d, input logic rev);
        logic [15:0] w;
        logic [15:0] r;
        logic [63:0] q;
        for (int p = 0; p < 4; p++) begin
            w = {d[p*8 +: 8], d[(p+4)*8 +: 8]};
            r = {<<{w}};
            q[p*16 +: 16] = rev ? r : w;
        end
        return q;
    endfunction

    always_ff @(posedge CLK_32M) begin
        if (rst) begin
            state    <= st_idle;
            obj_ptr  <= 8'd0;
            ar_valid <= 1'b0;
            r_wait   <= 1'b0;
            span_req <= 1'b0;
        end else begin
            // an accepted ROM read runs to completion even across a line restart
            if (ar_valid && rom_rsp.arready) begin
                ar_valid <= 1'b0;
                r_wait   <= 1'b1;
            end
            if (r_wait && rom_rsp.rvalid) begin
                r_wait <= 1'b0;
            end

            if (line_start) begin
                state     <= st_load;
                obj_ptr   <= 8'd0;
                scan_line <= vpos + 9'd1;
            end else begin
                case (state)
                    st_idle: begin
                        state <= st_idle;
                    end
                    st_load: begin
                        if (obj_ptr >= 8'(obj_count)) begin
                            state <= st_idle;
                        end else if (!dma_busy) begin
                            state <= st_size;
                        end
                    end
                    st_size: begin
                        cur       <= obj_entry;
                        height_px <= 9'd16 << obj_entry.height;
                        width_cnt <= 4'd1 << obj_entry.width;
                        rel_y     <= scan_line - obj_entry.y + (9'd16 << obj_entry.height);
                        span_col  <= 3'd0;
                        state     <= st_code;
                    end
                    st_code: begin
                        if (!covers) begin
                            obj_ptr <= obj_ptr + 8'(width_cnt);
                            state   <= st_load;
                        end else begin
                            code_idx <= cur.code + 16'(row_y[8:4]) + 16'({col_eff, 3'b000});
                            state    <= st_fetch;
                        end
                    end
                    st_fetch: begin
                        // a read left over from the previous line must drain first
                        if (!ar_valid && !r_wait) begin
                            ar_valid <= 1'b1;
                            ar_addr  <= rom_base + 32'({code_idx, row_y[3:0], 3'b000});
                            state    <= st_wait_rom;
                        end
                    end
                    st_wait_rom: begin
                        if (r_wait && rom_rsp.rvalid) begin
                            span_data <= deswizzle(rom_rsp.rdata, cur.flip_x);
                            state     <= st_hand;
                        end
                    end
                    st_hand: begin
                        if (span_req == span_ack) begin
                            span.data    <= span_data;
                            span.color   <= cur.color;
                            span.x_start <= cur.x + 10'({span_col, 4'b0000});
                            span_req     <= ~span_req;
                            state        <= st_next;
                        end
                    end
                    st_next: begin
                        if (4'(span_col) == width_cnt - 4'd1) begin
                            obj_ptr <= obj_ptr + 8'(width_cnt);
                            state   <= st_load;
                        end else begin
                            span_col <= span_col + 3'd1;
                            state    <= st_code;
                        end
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

endmodule

//--- verification/sprite_model.svh
// reference model with staging RAM shadow, graphics ROM contents and expected line composition

// ============================================================================
// model state
// ============================================================================
logic [31:0] shadow_ram [staging_words];
logic [7:0]  exp_line   [line_len];

// every ROM word is a hash of its full byte address
function automatic logic [63:0] rom_word(input logic [31:0] addr);
    logic [31:0] h1;
    logic [31:0] h2;
    h1 = (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    h2 = {h1[15:0], h1[31:16]} * 32'h85eb_ca6b + addr;
    return {h2, h1};
endfunction

// plane p takes ROM byte p as its high byte and ROM byte p+4 as its low byte,
// pixel 0 sits in the top bit unless the object is flipped in x
function automatic logic [3:0] pixel_bits(input logic [63:0] w, input int i, input logic flip);
    logic [15:0] plane;
    logic [3:0]  b;
    int          pos;
    pos = flip ? i : 15 - i;
    for (int p = 0; p < 4; p++) begin
        plane = {w[p*8 +: 8], w[(p+4)*8 +: 8]};
        b[p] = plane[pos];
    end
    return b;
endfunction

// builds the expected line from the shadow of the staging RAM, which equals
// the object table once a copy has finished
task automatic compose_line(input int line);
    obj_desc_t   d;
    int          k;
    int          h;
    int          wc;
    int          rel;
    int          row;
    int          colr;
    logic [15:0] code_idx;
    logic [31:0] addr;
    logic [63:0] w;
    logic [3:0]  b;
    for (int i = 0; i < line_len; i++) begin
        exp_line[i] = 8'd0;
    end
    k = 0;
    while (k < obj_count) begin
        d   = obj_desc_t'({shadow_ram[2*k+1], shadow_ram[2*k]});
        h   = 16 << d.height;
        wc  = 1 << d.width;
        rel = (((line - int'(d.y) + h) % line_len) + line_len) % line_len;
        if (rel < h) begin
            row = d.flip_y ? (h - 1 - rel) : rel;
            for (int c = 0; c < wc; c++) begin
                // the tile column is mirrored under flip x, the screen column is not
                colr     = d.flip_x ? (wc - 1 - c) : c;
                code_idx = 16'(int'(d.code) + row / 16 + colr * 8);
                addr     = rom_base + 32'(code_idx) * 32'd128 + 32'((row % 16) * 8);
                w        = rom_word(addr);
                for (int i = 0; i < 16; i++) begin
                    b = pixel_bits(w, i, d.flip_x);
                    if (b != 4'd0) begin
                        exp_line[(int'(d.x) + c * 16 + i) % line_len] = {d.color, b};
                    end
                end
            end
        end
        k += wc;
    end
endtask

//--- verification/sprite_tb.sv
// testbench for the sprite engine with CPU driver, ROM slave, line checks and watchdog
`timescale 1ns/1ps

module sprite_tb import sprite_pkg::*; ();

    // lines plus setup traffic counted in line lengths
    localparam int     line_budget = 90;
    localparam longint timeout_ns  = longint'(line_budget) * 1400 * 100 * 12 / 10;

    logic         CLK_32M;
    logic         rst;
    axil_wr_req_t cpu_wr_req;
    axil_wr_rsp_t cpu_wr_rsp;
    axil_rd_req_t cpu_rd_req;
    axil_rd_rsp_t cpu_rd_rsp;
    logic         dma_start;
    logic         dma_busy;
    axil_rd_req_t rom_req;
    axil_rd_rsp_t rom_rsp;
    logic         line_start;
    logic [8:0]   vpos;
    logic         ce_pix;
    logic [7:0]   pix;
    logic         pix_valid;

    logic [31:0]  lcg_state;
    int           errors;
    int           checks;
    int           stall_count;

    `include "sprite_model.svh"

    sprite_top sprite_top_i (.*);

    always #50 CLK_32M = ~CLK_32M;

    function automatic int unsigned rand_below(input int unsigned n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 8) % n;
    endfunction

    // ========================================================================
    // CPU side
    // ========================================================================
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        cpu_wr_req.awaddr  = 32'(addr);
        cpu_wr_req.awvalid = 1'b1;
        cpu_wr_req.wdata   = data;
        cpu_wr_req.wstrb   = strb;
        cpu_wr_req.wvalid  = 1'b1;
        while (!(aw_done && w_done)) begin
            if (cpu_wr_rsp.awready && cpu_wr_req.awvalid) aw_done = 1'b1;
            if (cpu_wr_rsp.wready && cpu_wr_req.wvalid) w_done = 1'b1;
            @(negedge CLK_32M);
            if (aw_done) cpu_wr_req.awvalid = 1'b0;
            if (w_done) cpu_wr_req.wvalid = 1'b0;
        end
        while (!cpu_wr_rsp.bvalid) @(negedge CLK_32M);
        checks++;
        assert (cpu_wr_rsp.bresp == resp_okay) else begin
            $display("[FAIL] %0t bresp: got %0d expected %0d", $time, cpu_wr_rsp.bresp,
                     resp_okay);
            errors++;
        end
        @(negedge CLK_32M);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) shadow_ram[addr][b*8 +: 8] = data[b*8 +: 8];
        end
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        cpu_rd_req.araddr  = 32'(addr);
        cpu_rd_req.arvalid = 1'b1;
        while (!cpu_rd_rsp.arready) @(negedge CLK_32M);
        @(negedge CLK_32M);
        cpu_rd_req.arvalid = 1'b0;
        while (!cpu_rd_rsp.rvalid) @(negedge CLK_32M);
        data = cpu_rd_rsp.rdata[31:0];
        resp = cpu_rd_rsp.rresp;
        @(negedge CLK_32M);
    endtask

    task automatic put_obj(input int k, input obj_desc_t d);
        axi_write(8'(2 * k), d[31:0], 4'hf);
        axi_write(8'(2 * k + 1), d[63:32], 4'hf);
    endtask

    task automatic run_dma();
        dma_start = 1'b1;
        @(negedge CLK_32M);
        dma_start = 1'b0;
        while (dma_busy) @(negedge CLK_32M);
    endtask

    // object of the given size that covers the given line somewhere in its height
    function automatic obj_desc_t make_obj(input int hh, input int ww, input logic fx,
                                           input logic fy, input int line, input int x);
        obj_desc_t d;
        d        = '0;
        d.height = 2'(hh);
        d.width  = 2'(ww);
        d.flip_x = fx;
        d.flip_y = fy;
        d.y      = 9'(line + 1 + int'(rand_below(16 << hh)));
        d.code   = 16'(rand_below(65536));
        d.color  = 4'(rand_below(16));
        d.x      = 10'(x);
        return d;
    endfunction

    // ========================================================================
    // line timing and pixel checks
    // ========================================================================
    task automatic run_line(input int v, input logic check);
        logic [7:0] got [visible_px];
        int         n;
        n = 0;
        for (int c = 0; c < 1400; c++) begin
            @(negedge CLK_32M);
            if (pix_valid) begin
                if (n < visible_px) begin
                    got[n] = pix;
                end
                n++;
            end
            line_start = (c == 0);
            vpos       = 9'(v);
            ce_pix     = (c >= 600) && (c % 2 == 0);
        end
        if (check) begin
            checks++;
            assert (n == visible_px) else begin
                $display("line %0d delivered %0d pixels instead of %0d", v, n, visible_px);
                errors++;
            end
            for (int i = 0; i < n && i < visible_px; i++) begin
                checks++;
                assert (got[i] === exp_line[i]) else begin
                    $display("[FAIL] %0t pix[%0d] line %0d: got %h expected %h", $time, i, v,
                             got[i], exp_line[i]);
                    errors++;
                end
            end
        end
    endtask

    // the line is composed during the previous line and shown in its own
    task automatic check_line(input int line);
        run_dma();
        compose_line(line);
        run_line(line - 1, 1'b0);
        run_line(line, 1'b1);
    endtask

    // ROM slave with random stalls before arready and before rvalid
    initial begin
        int          stall;
        logic [31:0] addr;
        rom_rsp     = '0;
        stall_count = 0;
        forever begin
            @(negedge CLK_32M);
            if (rom_req.arvalid) begin
                stall = rand_below(6);
                if (stall > 0) stall_count++;
                repeat (stall) @(negedge CLK_32M);
                addr = rom_req.araddr;
                rom_rsp.arready = 1'b1;
                @(negedge CLK_32M);
                rom_rsp.arready = 1'b0;
                repeat (rand_below(6)) @(negedge CLK_32M);
                rom_rsp.rdata  = rom_word(addr);
                rom_rsp.rvalid = 1'b1;
                // the data stays offered until the scanner is ready for it
                while (!rom_req.rready) @(negedge CLK_32M);
                @(negedge CLK_32M);
                rom_rsp.rvalid = 1'b0;
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        int          err_start;
        int          busy_cycles;
        int          line;
        int          k1;
        int          k2;
        int          x1;
        logic [31:0] rd;
        logic [1:0]  rr;
        obj_desc_t   d1;
        obj_desc_t   d2;
        lcg_state  = 32'hf801_c174;
        errors     = 0;
        checks     = 0;
        CLK_32M    = 1'b0;
        rst        = 1'b1;
        cpu_wr_req = '0;
        cpu_rd_req = '0;
        cpu_rd_req.rready = 1'b1;
        cpu_wr_req.bready = 1'b1;
        dma_start  = 1'b0;
        line_start = 1'b0;
        vpos       = 9'd0;
        ce_pix     = 1'b0;
        repeat (3) @(negedge CLK_32M);
        rst = 1'b0;
        @(negedge CLK_32M);

        // test 1 fills the RAM at random, overwrites bytes under strobes and reads back
        err_start = errors;
        for (int a = 0; a < staging_words; a++) begin
            axi_write(8'(a), (rand_below(65536) << 16) | rand_below(65536), 4'hf);
        end
        repeat (64) axi_write(8'(rand_below(256)), lcg_state ^ 32'h3c5a_96e1, 4'(rand_below(16)));
        for (int a = 0; a < staging_words; a++) begin
            axi_read(8'(a), rd, rr);
            checks++;
            assert (rd == shadow_ram[a]) else begin
                $display("[FAIL] %0t rdata[%0d]: got %h expected %h", $time, a, rd,
                         shadow_ram[a]);
                errors++;
            end
            checks++;
            assert (rr == resp_okay) else begin
                $display("[FAIL] %0t rresp[%0d]: got %0d expected %0d", $time, a, rr,
                         resp_okay);
                errors++;
            end
        end
        $display("test 1 cpu write and read back: %0d errors", errors - err_start);

        // test 2 times the copy and gives a second pulse while busy
        err_start = errors;
        for (int a = 0; a < staging_words; a++) axi_write(8'(a), 32'd0, 4'hf);
        dma_start = 1'b1;
        @(negedge CLK_32M);
        dma_start   = 1'b0;
        busy_cycles = 0;
        while (dma_busy) begin
            busy_cycles++;
            dma_start = (busy_cycles == 100);
            @(negedge CLK_32M);
        end
        repeat (4) begin
            checks++;
            assert (!dma_busy) else begin
                $display("dma_busy rose again after a pulse given while busy");
                errors++;
            end
            @(negedge CLK_32M);
        end
        checks++;
        assert (busy_cycles == 257) else begin
            $display("[FAIL] %0t dma_busy cycles: got %0d expected 257", $time, busy_cycles);
            errors++;
        end
        $display("test 2 dma busy timing: %0d errors", errors - err_start);

        // both line RAMs are cleared by being displayed once
        run_line(0, 1'b0);
        run_line(0, 1'b0);

        // test 3 covers every size without flips
        err_start = errors;
        for (int hh = 0; hh < 4; hh++) begin
            for (int ww = 0; ww < 4; ww++) begin
                line = 20 + rand_below(180);
                k1   = rand_below(120);
                put_obj(k1, make_obj(hh, ww, 1'b0, 1'b0, line, rand_below(300)));
                check_line(line);
                put_obj(k1, '0);
            end
        end
        $display("test 3 single objects: %0d errors", errors - err_start);

        // test 4 covers the flips with half of the objects across the x wrap
        err_start = errors;
        for (int s = 0; s < 6; s++) begin
            line = 20 + rand_below(180);
            k1   = rand_below(120);
            x1   = (s % 2 == 1) ? 480 + rand_below(32) : rand_below(300);
            put_obj(k1, make_obj(rand_below(4), rand_below(4), (s / 2) != 1, (s / 2) != 0,
                                 line, x1));
            check_line(line);
            put_obj(k1, '0);
        end
        $display("test 4 flips and x wrap: %0d errors", errors - err_start);

        // test 5 checks overlap priority and then an empty line for the clear-behind
        err_start = errors;
        for (int s = 0; s < 4; s++) begin
            line = 20 + rand_below(180);
            k1   = rand_below(32);
            k2   = k1 + 8 + rand_below(32);
            x1   = 16 + rand_below(200);
            d1   = make_obj(rand_below(2), rand_below(2), 1'b0, 1'b0, line, x1);
            d2   = make_obj(rand_below(2), rand_below(2), 1'(s), 1'b0, line,
                            x1 + rand_below(16) - 8);
            put_obj(k1, d1);
            put_obj(k2, d2);
            check_line(line);
            put_obj(k1, '0);
            put_obj(k2, '0);
            check_line(line + 1);
        end
        $display("test 5 overlap and clear-behind: %0d errors", errors - err_start);

        err_start = errors;
        checks++;
        assert (stall_count > 0) else begin
            $display("the ROM slave never stalled an address handshake");
            errors++;
        end
        $display("test 6 rom back-pressure, %0d stalled reads: %0d errors", stall_count,
                 errors - err_start);

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
